//--- include/uart_periph_config.svh
`ifndef UART_PERIPH_CONFIG_SVH
`define UART_PERIPH_CONFIG_SVH

// bus slot in hid_addr[17:15]
`define UART_BUS_SLOT 3'd6

// actions selected by hid_addr[13:12]
`define UART_ACT_PUSH 2'b00
`define UART_ACT_POP 2'b01
`define UART_ACT_BAUD 2'b10

`define UART_CNT_W 12
`define UART_FIFO_DEPTH 16

`define UART_BAUD_W 16
`define UART_BAUD_RESET 16'd54

`endif

//--- src/uart_periph_pkg.sv
`default_nettype none

package uart_periph_pkg;

   // transmit sequencer steps
   typedef enum logic [2:0]
   {
      UTX_IDLE,
      UTX_EMPTY,
      UTX_POP,
      UTX_START,
      UTX_INUSE
   } utx_state_t;

   // one queue slot, error flag on top
   typedef struct packed
   {
      logic       err;
      logic [7:0] data;
   } uart_entry_t;

endpackage

`default_nettype wire

//--- src/baud_timer.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_periph_config.svh"

module baud_timer (
   input  wire                    msoc_clk,
   input  wire                    rstn,
   input  wire                    run_i,
   input  wire                    restart_i,
   input  wire [`UART_BAUD_W-1:0] baud_i,
   output logic                   tick_o,
   output logic                   half_tick_o
);

   logic [`UART_BAUD_W-1:0] cnt_q;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         cnt_q <= '0;
      else if (restart_i)
         cnt_q <= baud_i - 1'b1;
      else if (run_i)
         cnt_q <= (cnt_q == '0) ? baud_i - 1'b1 : cnt_q - 1'b1; // reload on expiry
   end

   assign tick_o      = run_i && !restart_i && (cnt_q == '0);
   // half a period after the reload
   assign half_tick_o = run_i && (cnt_q == baud_i - (baud_i >> 1));

endmodule

`default_nettype wire

//--- src/uart_fifo.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_periph_config.svh"

module uart_fifo
   import uart_periph_pkg::*;
#(
   parameter int depth = `UART_FIFO_DEPTH
)
(
   input  wire                    msoc_clk,
   input  wire                    rstn,
   input  wire                    wr_en_i,
   input  uart_entry_t            din_i,
   input  wire                    rd_en_i,
   output uart_entry_t            dout_o,
   output logic                   full_o,
   output logic                   empty_o,
   output logic [`UART_CNT_W-1:0] wrcnt_o,
   output logic [`UART_CNT_W-1:0] rdcnt_o
);

   localparam int addr_w = $clog2(depth);

   uart_entry_t       mem [depth];
   logic [addr_w:0]   wr_ptr, rd_ptr; // extra bit tells full from empty
   logic              do_wr, do_rd;

   assign empty_o = (wr_ptr == rd_ptr);
   assign full_o  = (wr_ptr[addr_w] != rd_ptr[addr_w]) &&
                    (wr_ptr[addr_w-1:0] == rd_ptr[addr_w-1:0]);
   assign do_wr   = wr_en_i && !full_o;  // drop when full
   assign do_rd   = rd_en_i && !empty_o; // ignore when empty
   assign dout_o  = mem[rd_ptr[addr_w-1:0]];

   always_ff @(posedge msoc_clk)
   begin
      if (do_wr)
         mem[wr_ptr[addr_w-1:0]] <= din_i;
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         wrcnt_o <= '0;
         rdcnt_o <= '0;
      end
      else
      begin
         if (do_wr)
         begin
            wr_ptr  <= wr_ptr + 1'b1;
            wrcnt_o <= wrcnt_o + 1'b1; // wraps at counter width
         end
         if (do_rd)
         begin
            rd_ptr  <= rd_ptr + 1'b1;
            rdcnt_o <= rdcnt_o + 1'b1;
         end
      end
   end

endmodule

`default_nettype wire

//--- src/uart_tx_seq.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_seq
   import uart_periph_pkg::*;
(
   input  wire  msoc_clk,
   input  wire  rstn,
   input  wire  tx_empty_i,
   input  wire  tx_busy_i,
   output logic pop_o,
   output logic load_o
);

   utx_state_t state_q, state_d;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
         state_q <= UTX_IDLE;
      else
         state_q <= state_d;
   end

   always_comb
   begin
      state_d = state_q;
      case (state_q)
         UTX_IDLE:  state_d = UTX_EMPTY;
         UTX_EMPTY: if (!tx_empty_i) state_d = UTX_POP; // wait for data
         UTX_POP:   state_d = UTX_START;
         UTX_START: state_d = UTX_INUSE;
         UTX_INUSE: if (!tx_busy_i) state_d = UTX_IDLE; // frame finished
         default:   state_d = UTX_IDLE;
      endcase
   end

   assign pop_o  = (state_q == UTX_POP);
   assign load_o = (state_q == UTX_START);

endmodule

`default_nettype wire

//--- src/uart_tx_shift.sv
`timescale 1ns/100ps
`default_nettype none

module uart_tx_shift (
   input  wire       msoc_clk,
   input  wire       rstn,
   input  wire       load_i,
   input  wire [7:0] byte_i,
   input  wire       tick_i,
   output logic      tx_o,
   output logic      busy_o,
   output logic      timer_run_o,
   output logic      timer_restart_o
);

   logic [9:0] frame_q; // stop, data, start from msb to lsb
   logic [3:0] bits_q;  // bits left in the frame
   logic [7:0] byte_q;

   // head byte as it stood in the pop cycle, before the queue advanced
   always_ff @(posedge msoc_clk)
   begin
      byte_q <= byte_i;
   end

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         frame_q <= '1; // line idles high
         bits_q  <= '0;
      end
      else if (load_i && !busy_o)
      begin
         frame_q <= {1'b1, byte_q, 1'b0};
         bits_q  <= 4'd10;
      end
      else if (busy_o && tick_i)
      begin
         frame_q <= {1'b1, frame_q[9:1]}; // lsb first
         bits_q  <= bits_q - 1'b1;
      end
   end

   assign busy_o          = (bits_q != '0);
   assign tx_o            = frame_q[0];
   assign timer_run_o     = busy_o;
   assign timer_restart_o = load_i && !busy_o; // align bit period to the load

endmodule

`default_nettype wire

//--- src/uart_rx_deframe.sv
`timescale 1ns/100ps
`default_nettype none

module uart_rx_deframe
   import uart_periph_pkg::*;
(
   input  wire         msoc_clk,
   input  wire         rstn,
   input  wire         rx_i,
   input  wire         tick_i,
   input  wire         half_tick_i,
   output logic        valid_o,
   output uart_entry_t entry_o,
   output logic        timer_run_o,
   output logic        timer_restart_o
);

   localparam logic [1:0] st_idle  = 2'd0;
   localparam logic [1:0] st_start = 2'd1;
   localparam logic [1:0] st_data  = 2'd2;
   localparam logic [1:0] st_stop  = 2'd3;

   logic [1:0] sync_q;  // two-flop synchronizer
   logic [2:0] samp_q;  // last three synchronized samples
   logic       maj, maj_q;
   logic [1:0] state_q;
   logic [2:0] bit_q;
   logic [7:0] data_q;
   logic       fall;

   assign maj  = (samp_q[0] & samp_q[1]) | (samp_q[0] & samp_q[2]) | (samp_q[1] & samp_q[2]);
   assign fall = maj_q && !maj; // start edge

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         sync_q  <= '1;
         samp_q  <= '1;
         maj_q   <= 1'b1;
         state_q <= st_idle;
         bit_q   <= '0;
         valid_o <= 1'b0;
      end
      else
      begin
         sync_q  <= {sync_q[0], rx_i};
         samp_q  <= {samp_q[1:0], sync_q[1]};
         maj_q   <= maj;
         valid_o <= 1'b0;
         case (state_q)
            st_idle:
               if (fall)
                  state_q <= st_start;
            st_start:
               if (half_tick_i)
                  state_q <= maj ? st_idle : st_data; // glitch if high again
            st_data:
               if (tick_i)
               begin
                  bit_q <= bit_q + 1'b1;
                  if (bit_q == 3'd7)
                     state_q <= st_stop;
               end
            default:
               if (tick_i)
               begin
                  valid_o <= 1'b1;
                  state_q <= st_idle;
               end
         endcase
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (state_q == st_data && tick_i)
         data_q <= {maj, data_q[7:1]}; // lsb arrives first
      if (state_q == st_stop && tick_i)
         entry_o <= '{err: !maj, data: data_q}; // low stop bit is a framing error
   end

   assign timer_run_o     = (state_q != st_idle);
   // restart on the edge, then again at mid start bit for mid-bit ticks
   assign timer_restart_o = (state_q == st_idle && fall) ||
                            (state_q == st_start && half_tick_i && !maj);

endmodule

`default_nettype wire

//--- src/uart_regs.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_periph_config.svh"

module uart_regs
   import uart_periph_pkg::*;
(
   input  wire                     msoc_clk,
   input  wire                     rstn,
   input  wire                     hid_en_i,
   input  wire [7:0]               hid_we_i,
   input  wire [17:0]              hid_addr_i,
   input  wire [63:0]              hid_wrdata_i,
   input  uart_entry_t             rx_head_i,
   input  wire                     rx_full_i,
   input  wire                     rx_empty_i,
   input  wire                     tx_full_i,
   input  wire [`UART_CNT_W-1:0]   tx_wrcnt_i,
   input  wire [`UART_CNT_W-1:0]   tx_rdcnt_i,
   input  wire [`UART_CNT_W-1:0]   rx_wrcnt_i,
   input  wire [`UART_CNT_W-1:0]   rx_rdcnt_i,
   output logic [63:0]             hid_rddata_o,
   output logic                    tx_push_o,
   output logic [7:0]              tx_byte_o,
   output logic                    rx_pop_o,
   output logic [`UART_BAUD_W-1:0] baud_o
);

   localparam int pad_w = 16 - `UART_CNT_W;

   logic uart_hit; // slot matches and bit 14 set
   logic wr_hit;

   assign uart_hit = (hid_addr_i[17:15] == `UART_BUS_SLOT) && hid_addr_i[14];
   assign wr_hit   = hid_en_i && (|hid_we_i) && uart_hit;

   always_ff @(posedge msoc_clk or negedge rstn)
   begin
      if (!rstn)
      begin
         tx_push_o <= 1'b0;
         rx_pop_o  <= 1'b0;
         baud_o    <= `UART_BAUD_RESET;
      end
      else
      begin
         tx_push_o <= wr_hit && (hid_addr_i[13:12] == `UART_ACT_PUSH); // one-cycle strobes
         rx_pop_o  <= wr_hit && (hid_addr_i[13:12] == `UART_ACT_POP);
         if (wr_hit && (hid_addr_i[13:12] == `UART_ACT_BAUD))
            baud_o <= hid_wrdata_i[`UART_BAUD_W-1:0];
      end
   end

   always_ff @(posedge msoc_clk)
   begin
      if (wr_hit && (hid_addr_i[13:12] == `UART_ACT_PUSH))
         tx_byte_o <= hid_wrdata_i[7:0]; // pairs with tx_push_o
   end

   always_comb
   begin
      hid_rddata_o = 64'b0;
      if (uart_hit)
      begin
         if (hid_addr_i[13])
            hid_rddata_o = {{pad_w{1'b0}}, tx_wrcnt_i,
                            {pad_w{1'b0}}, tx_rdcnt_i,
                            {pad_w{1'b0}}, rx_wrcnt_i,
                            {pad_w{1'b0}}, rx_rdcnt_i};
         else
            hid_rddata_o = {52'b0, rx_full_i, tx_full_i, rx_empty_i, rx_head_i}; // status word
      end
   end

endmodule

`default_nettype wire

//--- src/uart_periph_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_periph_config.svh"

module uart_periph_top
   import uart_periph_pkg::*;
(
   input  wire         msoc_clk,
   input  wire         rstn,
   input  wire         hid_en_i,
   input  wire [7:0]   hid_we_i,
   input  wire [17:0]  hid_addr_i,
   input  wire [63:0]  hid_wrdata_i,
   output logic [63:0] hid_rddata_o,
   input  wire         uart_rx_i,
   output logic        uart_tx_o
);

   logic                   tx_push, rx_pop;
   logic [7:0]             tx_byte;
   logic [`UART_BAUD_W-1:0] baud;
   uart_entry_t            tx_head, rx_head, rx_entry;
   logic                   tx_full, tx_empty, rx_full, rx_empty;
   logic [`UART_CNT_W-1:0] tx_wrcnt, tx_rdcnt, rx_wrcnt, rx_rdcnt;
   logic                   seq_pop, seq_load, tx_busy;
   logic                   tx_run, tx_restart, tx_tick;
   logic                   rx_run, rx_restart, rx_tick, rx_half_tick, rx_valid;

   uart_regs regs0 (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en_i),
      .hid_we_i     (hid_we_i),
      .hid_addr_i   (hid_addr_i),
      .hid_wrdata_i (hid_wrdata_i),
      .rx_head_i    (rx_head),
      .rx_full_i    (rx_full),
      .rx_empty_i   (rx_empty),
      .tx_full_i    (tx_full),
      .tx_wrcnt_i   (tx_wrcnt),
      .tx_rdcnt_i   (tx_rdcnt),
      .rx_wrcnt_i   (rx_wrcnt),
      .rx_rdcnt_i   (rx_rdcnt),
      .hid_rddata_o (hid_rddata_o),
      .tx_push_o    (tx_push),
      .tx_byte_o    (tx_byte),
      .rx_pop_o     (rx_pop),
      .baud_o       (baud)
   );

   uart_fifo tx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .wr_en_i  (tx_push),
      .din_i    ({1'b0, tx_byte}), // tx entries never carry an error
      .rd_en_i  (seq_pop),
      .dout_o   (tx_head),
      .full_o   (tx_full),
      .empty_o  (tx_empty),
      .wrcnt_o  (tx_wrcnt),
      .rdcnt_o  (tx_rdcnt)
   );

   uart_fifo rx_fifo (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .wr_en_i  (rx_valid),
      .din_i    (rx_entry),
      .rd_en_i  (rx_pop),
      .dout_o   (rx_head),
      .full_o   (rx_full),
      .empty_o  (rx_empty),
      .wrcnt_o  (rx_wrcnt),
      .rdcnt_o  (rx_rdcnt)
   );

   uart_tx_seq tx_seq0 (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .tx_empty_i (tx_empty),
      .tx_busy_i  (tx_busy),
      .pop_o      (seq_pop),
      .load_o     (seq_load)
   );

   baud_timer tx_timer (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .run_i       (tx_run),
      .restart_i   (tx_restart),
      .baud_i      (baud),
      .tick_o      (tx_tick),
      .half_tick_o ()
   );

   uart_tx_shift tx_shift0 (
      .msoc_clk        (msoc_clk),
      .rstn            (rstn),
      .load_i          (seq_load),
      .byte_i          (tx_head.data),
      .tick_i          (tx_tick),
      .tx_o            (uart_tx_o),
      .busy_o          (tx_busy),
      .timer_run_o     (tx_run),
      .timer_restart_o (tx_restart)
   );

   baud_timer rx_timer (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .run_i       (rx_run),
      .restart_i   (rx_restart),
      .baud_i      (baud),
      .tick_o      (rx_tick),
      .half_tick_o (rx_half_tick)
   );

   uart_rx_deframe rx_deframe0 (
      .msoc_clk        (msoc_clk),
      .rstn            (rstn),
      .rx_i            (uart_rx_i),
      .tick_i          (rx_tick),
      .half_tick_i     (rx_half_tick),
      .valid_o         (rx_valid),
      .entry_o         (rx_entry),
      .timer_run_o     (rx_run),
      .timer_restart_o (rx_restart)
   );

endmodule

`default_nettype wire

//--- verification/uart_periph_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "uart_periph_config.svh"

module uart_periph_tb
   import uart_periph_pkg::*;
();

   localparam int n_loop   = 8;   // loopback bytes
   localparam int n_drv    = 6;   // frames from the serial driver
   localparam int n_fill   = 20;  // pushes behind the first byte in the overflow test
   localparam int big_baud = 100;
   // every frame at its worst divisor, plus room for bus traffic
   localparam int cycle_limit = n_loop * 10 * 20 + n_drv * 13 * 20 +
                                (n_fill + 1) * 10 * big_baud + 5000;

   logic        msoc_clk;
   logic        rstn;
   logic        hid_en_i;
   logic [7:0]  hid_we_i;
   logic [17:0] hid_addr_i;
   logic [63:0] hid_wrdata_i;
   wire  [63:0] hid_rddata_o;
   wire         uart_rx_i;
   wire         uart_tx_o;
   logic        loopback;
   logic        drv_line;

   int          errors = 0;
   int          checks = 0;
   int          cycle_cnt = 0;
   int          cur_baud;
   string       test_name;
   logic        mon_busy;

   logic [`UART_CNT_W-1:0] m_tx_wr, m_tx_rd, m_rx_wr, m_rx_rd; // model counters
   logic [7:0]             tx_expect[$];  // bytes the monitor should see
   uart_entry_t            rx_expect[$];  // model of the receive queue

   assign uart_rx_i = loopback ? uart_tx_o : drv_line;

   uart_periph_top dut0 (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en_i),
      .hid_we_i     (hid_we_i),
      .hid_addr_i   (hid_addr_i),
      .hid_wrdata_i (hid_wrdata_i),
      .hid_rddata_o (hid_rddata_o),
      .uart_rx_i    (uart_rx_i),
      .uart_tx_o    (uart_tx_o)
   );

   initial msoc_clk = 1'b0;
   always #5 msoc_clk = ~msoc_clk;

   always @(posedge msoc_clk)
   begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit)
      begin
         $display("timeout after %0d cycles in %s, sequencer in %s, %0d errors so far",
                  cycle_limit, test_name, dut0.tx_seq0.state_q.name(), errors);
         $display("Test FAILED");
         $finish;
      end
   end

   task automatic check_value(input string name, input logic [63:0] exp,
                              input logic [63:0] act);
      checks++;
      assert (act === exp)
      else
      begin
         errors++;
         $display("FAIL %s (%s): expected %h, actual %h", test_name, name, exp, act);
      end
   endtask

   function automatic logic [17:0] uart_addr(input logic [1:0] act);
      return {`UART_BUS_SLOT, 1'b1, act, 12'($urandom)}; // low bits are don't care
   endfunction

   task automatic write_bus(input logic [17:0] addr, input logic [63:0] data);
      @(posedge msoc_clk);
      hid_en_i     <= 1'b1;
      hid_we_i     <= 8'($urandom_range(255, 1)); // any strobe counts
      hid_addr_i   <= addr;
      hid_wrdata_i <= data;
      @(posedge msoc_clk);
      hid_en_i <= 1'b0;
      hid_we_i <= 8'h00;
   endtask

   task automatic read_bus(input logic [17:0] addr, output logic [63:0] data);
      @(posedge msoc_clk);
      hid_en_i   <= 1'b1;
      hid_we_i   <= 8'h00;
      hid_addr_i <= addr;
      @(negedge msoc_clk);
      data = hid_rddata_o; // combinational read
   endtask

   // receive queue drops entries that arrive while full
   task automatic deliver_rx(input uart_entry_t entry);
      if (rx_expect.size() < `UART_FIFO_DEPTH)
      begin
         rx_expect.push_back(entry);
         m_rx_wr++;
      end
   endtask

   task automatic push_byte(input logic [7:0] data);
      logic [`UART_CNT_W-1:0] level;
      level = m_tx_wr - m_tx_rd;
      write_bus(uart_addr(2'b00), {56'($urandom), data});
      if (level < `UART_FIFO_DEPTH)
      begin
         m_tx_wr++;
         tx_expect.push_back(data);
      end
   endtask

   task automatic check_status(input string name);
      logic [63:0]            rd;
      logic [63:0]            exp;
      logic [63:0]            mask;
      logic [`UART_CNT_W-1:0] level;
      level   = m_tx_wr - m_tx_rd;
      mask    = '1;
      exp     = '0;
      exp[11] = (rx_expect.size() == `UART_FIFO_DEPTH);
      exp[10] = (level == `UART_FIFO_DEPTH);
      exp[9]  = (rx_expect.size() == 0);
      if (rx_expect.size() == 0)
         mask[8:0] = '0; // head is stale when empty
      else
         exp[8:0] = rx_expect[0];
      read_bus(uart_addr({1'b0, 1'($urandom)}), rd);
      check_value(name, exp, rd & mask);
   endtask

   task automatic check_counters(input string name);
      logic [63:0]            rd;
      logic [63:0]            exp;
      logic [`UART_CNT_W-1:0] tx_gap, rx_gap;
      exp        = '0;
      exp[63:48] = m_tx_wr;
      exp[47:32] = m_tx_rd;
      exp[31:16] = m_rx_wr;
      exp[15:0]  = m_rx_rd;
      read_bus(uart_addr({1'b1, 1'($urandom)}), rd);
      check_value(name, exp, rd);
      tx_gap = rd[48 +: `UART_CNT_W] - rd[32 +: `UART_CNT_W];
      rx_gap = rd[16 +: `UART_CNT_W] - rd[0 +: `UART_CNT_W];
      checks++;
      assert (tx_gap <= `UART_FIFO_DEPTH && rx_gap <= `UART_FIFO_DEPTH)
      else
      begin
         errors++;
         $display("%s: counter gap exceeds queue depth (tx %0d, rx %0d)",
                  test_name, tx_gap, rx_gap);
      end
   endtask

   task automatic wait_tx_drained();
      while (tx_expect.size() != 0 || mon_busy)
         @(negedge msoc_clk);
      m_tx_rd = m_tx_wr; // every accepted byte went through the shifter
   endtask

   task automatic wait_rx_count(input logic [`UART_CNT_W-1:0] target);
      logic [63:0] rd;
      read_bus(uart_addr(2'b10), rd);
      while (rd[16 +: `UART_CNT_W] != target)
         read_bus(uart_addr(2'b10), rd);
   endtask

   task automatic pop_all();
      while (rx_expect.size() != 0)
      begin
         check_status("rx head");
         write_bus(uart_addr(2'b01), 64'($urandom));
         rx_expect.delete(0);
         m_rx_rd++;
      end
      check_status("rx drained");
   endtask

   task automatic drive_frame(input logic [7:0] data, input logic stop);
      logic [9:0] bits;
      bits = {stop, data, 1'b0};
      for (int i = 0; i < 10; i++)
      begin
         @(posedge msoc_clk);
         drv_line <= bits[i]; // lsb first after the start bit
         repeat (cur_baud - 1) @(posedge msoc_clk);
      end
      @(posedge msoc_clk);
      drv_line <= 1'b1;
      repeat (3 * cur_baud) @(posedge msoc_clk); // idle gap
      deliver_rx('{err: !stop, data: data});
   endtask

   // serial monitor on uart_tx_o, every cycle of every bit must match
   initial
   begin : tx_monitor
      logic [9:0] frame;
      logic       prev;
      logic       stable;
      prev     = 1'b1;
      mon_busy = 1'b0;
      forever
      begin
         @(negedge msoc_clk);
         if (rstn && prev && !uart_tx_o)
         begin
            mon_busy = 1'b1;
            checks++;
            assert (tx_expect.size() != 0)
            else
            begin
               errors++;
               $display("%s: frame started on uart_tx_o with nothing pushed", test_name);
            end
            frame = (tx_expect.size() != 0) ? {1'b1, tx_expect.pop_front(), 1'b0} : 10'h3fe;
            for (int i = 0; i < 10; i++)
            begin
               stable = 1'b1;
               for (int c = 0; c < cur_baud; c++)
               begin
                  if (i != 0 || c != 0)
                     @(negedge msoc_clk);
                  if (uart_tx_o !== frame[i])
                     stable = 1'b0;
               end
               check_value($sformatf("tx bit %0d of %h", i, frame[8:1]),
                           frame[i], stable ? frame[i] : ~frame[i]);
            end
            if (loopback)
               deliver_rx('{err: 1'b0, data: frame[8:1]}); // frame is on its way back
            mon_busy = 1'b0;
         end
         prev = uart_tx_o;
      end
   end

   initial
   begin : main
      logic [2:0]  slot;
      logic [63:0] rd;
      void'($urandom(2441));
      rstn         = 1'b0;
      hid_en_i     = 1'b0;
      hid_we_i     = 8'h00;
      hid_addr_i   = '0;
      hid_wrdata_i = '0;
      loopback     = 1'b1;
      drv_line     = 1'b1;
      m_tx_wr      = '0;
      m_tx_rd      = '0;
      m_rx_wr      = '0;
      m_rx_rd      = '0;
      cur_baud     = `UART_BAUD_RESET;
      test_name    = "reset";
      repeat (3) @(posedge msoc_clk);
      rstn <= 1'b1;

      @(negedge msoc_clk);
      check_value("tx idle", 1'b1, uart_tx_o);
      check_status("status after reset");
      check_counters("counters after reset");

      test_name = "loopback";
      cur_baud  = $urandom_range(20, 4);
      write_bus(uart_addr(2'b10), {48'($urandom), 16'(cur_baud)});
      for (int i = 0; i < n_loop; i++)
         push_byte(8'($urandom));
      wait_tx_drained();
      wait_rx_count(m_rx_wr);
      check_counters("counters after frames");
      pop_all();
      check_counters("counters after pops");

      test_name = "unmapped access";
      for (int i = 0; i < 12; i++)
      begin
         read_bus({`UART_BUS_SLOT, 1'b0, 14'($urandom)}, rd);
         check_value("slot 6 low half", '0, rd);
         slot = 3'($urandom);
         if (slot == `UART_BUS_SLOT)
            slot = 3'd2;
         read_bus({slot, 15'($urandom)}, rd);
         check_value("other slot", '0, rd);
         write_bus(uart_addr(2'b11), {$urandom, $urandom});
         write_bus({`UART_BUS_SLOT, 1'b0, 14'($urandom)}, {$urandom, $urandom});
         write_bus({slot, 15'($urandom)}, {$urandom, $urandom});
      end
      check_status("status after ignored writes");
      check_counters("counters after ignored writes");

      test_name = "serial driver";
      @(posedge msoc_clk);
      loopback <= 1'b0;
      for (int i = 0; i < n_drv; i++)
         drive_frame(8'($urandom), 1'($urandom)); // divisor must be unchanged
      wait_rx_count(m_rx_wr);
      check_counters("counters after frames");
      pop_all();
      check_counters("counters after pops");

      test_name = "overflow";
      cur_baud  = big_baud;
      write_bus(uart_addr(2'b10), {48'($urandom), 16'(cur_baud)});
      @(posedge msoc_clk);
      loopback <= 1'b1;
      push_byte(8'($urandom));
      @(negedge msoc_clk);
      while (uart_tx_o)
         @(negedge msoc_clk);
      m_tx_rd++; // first byte now sits in the shifter
      for (int i = 0; i < n_fill; i++)
         push_byte(8'($urandom));
      check_status("status when full");
      check_counters("counters when full");
      wait_tx_drained();
      wait_rx_count(m_rx_wr);
      check_status("status after frames");
      check_counters("counters after frames");
      pop_all();
      check_counters("counters after pops");

      $display("checks: %0d, errors: %0d", checks, errors);
      if (errors == 0)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

`default_nettype wire

//--- build.f
+incdir+include
src/uart_periph_pkg.sv
src/baud_timer.sv
src/uart_fifo.sv
src/uart_tx_seq.sv
src/uart_tx_shift.sv
src/uart_rx_deframe.sv
src/uart_regs.sv
src/uart_periph_top.sv
verification/uart_periph_tb.sv

//--- Bender.yml
package:
  name: uart_periph

sources:
  - include_dirs:
      - include
    files:
      - src/uart_periph_pkg.sv
      - src/baud_timer.sv
      - src/uart_fifo.sv
      - src/uart_tx_seq.sv
      - src/uart_tx_shift.sv
      - src/uart_rx_deframe.sv
      - src/uart_regs.sv
      - src/uart_periph_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - verification/uart_periph_tb.sv
